// File: dcache.f
hdl/cache_cfg_pkg.sv
hdl/cache_types_pkg.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/line_fill_buf.sv
hdl/writeback_buf.sv
hdl/dcache_ctrl.sv
hdl/dcache.sv
tests/mem_model.sv
tests/dcache_tb.sv

// File: hdl/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // address and data widths
    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int STRB_W   = WORD_W / 8;     // byte strobes per word

    // geometry
    localparam int WORDS    = 4;              // words per line
    localparam int SETS     = 16;
    localparam int WAYS     = 2;
    localparam int LINE_W   = WORDS * WORD_W; // 128 bits per line

    // address split: tag | index | offset
    localparam int OFFSET_W = 4;              // byte offset in line
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WSEL_W   = $clog2(WORDS);  // word select inside offset

endpackage

// File: hdl/cache_types_pkg.sv
package cache_types_pkg;
    import cache_cfg_pkg::*;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cpu_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_fill_req,
        st_fill_wait,
        st_refill
    } ctrl_state_e;

    // held CPU request, 69 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        cpu_op_e           op;
        logic [STRB_W-1:0] wstrb;
    } cpu_req_t;

    // tag lookup result, 29 bits
    typedef struct packed {
        logic             hit;
        logic             hit_way;
        logic             victim_way;
        logic             victim_valid;
        logic             victim_dirty;
        logic [TAG_W-1:0] victim_tag;
    } lookup_t;

    // byte-lane merge of a store into an existing word
    function automatic logic [WORD_W-1:0] merge_bytes(
        input logic [WORD_W-1:0] old_word,
        input logic [WORD_W-1:0] new_word,
        input logic [STRB_W-1:0] strb
    );
        logic [WORD_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: hdl/data_store.sv
module data_store
    import cache_cfg_pkg::*;
(
    input  logic                         clk,
    input  logic [INDEX_W-1:0]           rd_index,
    input  logic [INDEX_W-1:0]           wr_index,
    input  logic                         wr_way,
    input  logic [WORDS-1:0]             word_we,
    input  logic [LINE_W-1:0]            wr_line,
    output logic [WAYS-1:0][LINE_W-1:0]  way_lines
);
    // one word-wide array per way and word lane
    logic [WORD_W-1:0] mem [WAYS][WORDS][SETS];

    always_ff @(posedge clk) begin
        for (int i = 0; i < WORDS; i++) begin
            if (word_we[i]) begin
                mem[wr_way][i][wr_index] <= wr_line[i*WORD_W +: WORD_W];
            end
        end
    end

    // both ways of the set come out together
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            for (int i = 0; i < WORDS; i++) begin
                way_lines[w][i*WORD_W +: WORD_W] <= mem[w][i][rd_index];
            end
        end
    end

endmodule

// File: hdl/dcache.sv
module dcache
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              valid,
    input  logic              op,           // 1 store, 0 load
    input  logic [ADDR_W-1:0] addr,
    input  logic [STRB_W-1:0] wstrb,
    input  logic [WORD_W-1:0] wdata,
    output logic              data_valid,
    output logic [WORD_W-1:0] rdata,
    output logic              r_req,
    output logic              r_data_ready,
    output logic [ADDR_W-1:0] r_addr,
    input  logic              r_rdy,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  logic [WORD_W-1:0] r_data,
    output logic              w_req,
    output logic [ADDR_W-1:0] w_addr,
    output logic [WORD_W-1:0] w_data,
    output logic              w_valid,
    output logic              w_last,
    output logic              b_ready,
    input  logic              w_rdy,
    input  logic              w_data_ready,
    input  logic              b_valid
);
    cpu_req_t                    req_q;
    lookup_t                     lookup;
    logic [WAYS-1:0][LINE_W-1:0] way_lines;
    logic [LINE_W-1:0]           fill_line, wr_line, victim_line;
    logic [ADDR_W-1:0]           victim_addr;
    logic [WORDS-1:0]            word_we;
    logic req_take, tag_we, dirty_set, lru_touch, touch_way, wr_way;
    logic fill_done, wb_load, wb_done;

    // request register, loaded as the lookup read starts
    always_ff @(posedge clk) begin
        if (req_take) begin
            req_q.addr  <= addr;
            req_q.wdata <= wdata;
            req_q.op    <= cpu_op_e'(op);
            req_q.wstrb <= wstrb;
        end
    end

    tag_store i_tag_store (
        .clk(clk), .rst(rst),
        .rd_index(addr[OFFSET_W +: INDEX_W]),        // raw index, read during capture
        .wr_index(req_q.addr[OFFSET_W +: INDEX_W]),
        .wr_tag(req_q.addr[ADDR_W-1 -: TAG_W]), .wr_way(wr_way), .tag_we(tag_we),
        .dirty_set(dirty_set), .lru_touch(lru_touch), .touch_way(touch_way),
        .cmp_tag(req_q.addr[ADDR_W-1 -: TAG_W]), .lookup(lookup)
    );

    data_store i_data_store (
        .clk(clk), .rd_index(addr[OFFSET_W +: INDEX_W]),
        .wr_index(req_q.addr[OFFSET_W +: INDEX_W]), .wr_way(wr_way),
        .word_we(word_we), .wr_line(wr_line), .way_lines(way_lines)
    );

    line_fill_buf i_line_fill_buf (
        .clk(clk), .rst(rst), .ret_valid(ret_valid), .ret_last(ret_last),
        .r_data(r_data), .req(req_q), .fill_line(fill_line), .fill_done(fill_done)
    );

    writeback_buf i_writeback_buf (
        .clk(clk), .rst(rst), .load(wb_load), .victim_line(victim_line),
        .victim_addr(victim_addr), .w_rdy(w_rdy), .w_data_ready(w_data_ready),
        .b_valid(b_valid), .w_req(w_req), .w_addr(w_addr), .w_data(w_data),
        .w_valid(w_valid), .w_last(w_last), .b_ready(b_ready), .wb_done(wb_done)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk(clk), .rst(rst), .valid(valid), .req(req_q), .lookup(lookup),
        .way_lines(way_lines), .fill_line(fill_line), .fill_done(fill_done),
        .wb_done(wb_done), .r_rdy(r_rdy), .req_take(req_take), .tag_we(tag_we),
        .dirty_set(dirty_set), .lru_touch(lru_touch), .touch_way(touch_way),
        .wr_way(wr_way), .word_we(word_we), .wr_line(wr_line), .wb_load(wb_load),
        .victim_line(victim_line), .victim_addr(victim_addr), .r_req(r_req),
        .r_addr(r_addr), .r_data_ready(r_data_ready), .data_valid(data_valid),
        .rdata(rdata)
    );

endmodule

// File: hdl/dcache_ctrl.sv
module dcache_ctrl
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid,
    input  cpu_req_t                    req,
    input  lookup_t                     lookup,
    input  logic [WAYS-1:0][LINE_W-1:0] way_lines,
    input  logic [LINE_W-1:0]           fill_line,
    input  logic                        fill_done,
    input  logic                        wb_done,
    input  logic                        r_rdy,
    output logic                        req_take,
    output logic                        tag_we,
    output logic                        dirty_set,
    output logic                        lru_touch,
    output logic                        touch_way,
    output logic                        wr_way,
    output logic [WORDS-1:0]            word_we,
    output logic [LINE_W-1:0]           wr_line,
    output logic                        wb_load,
    output logic [LINE_W-1:0]           victim_line,
    output logic [ADDR_W-1:0]           victim_addr,
    output logic                        r_req,
    output logic [ADDR_W-1:0]           r_addr,
    output logic                        r_data_ready,
    output logic                        data_valid,
    output logic [WORD_W-1:0]           rdata
);
    ctrl_state_e        state_q;
    ctrl_state_e        state_d;
    logic               vway_q;             // way picked for the refill
    logic [WSEL_W-1:0]  wsel;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               is_store;
    logic               miss;
    logic [LINE_W-1:0]  hit_line;
    logic [WORD_W-1:0]  hit_word;
    logic [WORD_W-1:0]  fill_word;
    logic [WORD_W-1:0]  st_word;

    assign wsel     = req.addr[OFFSET_W-1 -: WSEL_W];
    assign index    = req.addr[OFFSET_W +: INDEX_W];
    assign tag      = req.addr[ADDR_W-1 -: TAG_W];
    assign is_store = (req.op == op_write);

    // data side, selected by the tag result
    assign hit_line  = way_lines[lookup.hit_way];
    assign hit_word  = hit_line[wsel*WORD_W +: WORD_W];
    assign fill_word = fill_line[wsel*WORD_W +: WORD_W];
    assign st_word   = merge_bytes(hit_word, req.wdata, req.wstrb);

    assign miss        = (state_q == st_lookup) && !lookup.hit;
    assign wb_load     = miss && lookup.victim_valid && lookup.victim_dirty;
    assign victim_line = way_lines[lookup.victim_way];
    assign victim_addr = {lookup.victim_tag, index, {OFFSET_W{1'b0}}};

    assign req_take     = (state_q == st_idle) && valid;
    assign r_req        = (state_q == st_fill_req);
    assign r_addr       = {tag, index, {OFFSET_W{1'b0}}};  // line aligned
    assign r_data_ready = (state_q == st_fill_wait);

    assign wr_way    = (state_q == st_refill) ? vway_q : lookup.hit_way;
    assign touch_way = wr_way;
    assign rdata     = (state_q == st_refill) ? fill_word : hit_word;

    // array writes and the CPU answer
    always_comb begin
        tag_we     = 1'b0;
        dirty_set  = 1'b0;
        lru_touch  = 1'b0;
        word_we    = '0;
        wr_line    = fill_line;
        data_valid = 1'b0;
        case (state_q)
            st_lookup: begin
                if (lookup.hit) begin
                    data_valid = 1'b1;
                    lru_touch  = 1'b1;
                    if (is_store) begin         // store hit, one word
                        tag_we        = 1'b1;
                        dirty_set     = 1'b1;
                        word_we[wsel] = 1'b1;
                        wr_line       = {WORDS{st_word}};
                    end
                end
            end
            st_refill: begin
                data_valid = 1'b1;
                lru_touch  = 1'b1;
                tag_we     = 1'b1;
                dirty_set  = is_store;          // merged store makes it dirty
                word_we    = '1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:       if (valid) state_d = st_lookup;
            st_lookup: begin
                if (lookup.hit) begin
                    state_d = st_idle;
                end else if (wb_load) begin
                    state_d = st_write_back;
                end else begin
                    state_d = st_fill_req;
                end
            end
            st_write_back: if (wb_done) state_d = st_fill_req;
            st_fill_req:   if (r_rdy) state_d = st_fill_wait;
            st_fill_wait:  if (fill_done) state_d = st_refill;
            st_refill:     state_d = st_idle;
            default:       state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            vway_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (miss) begin
                vway_q <= lookup.victim_way;
            end
        end
    end

endmodule

// File: hdl/line_fill_buf.sv
module line_fill_buf
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  logic [WORD_W-1:0] r_data,
    input  cpu_req_t          req,
    output logic [LINE_W-1:0] fill_line,
    output logic              fill_done
);
    logic [WSEL_W-1:0] beat_q;              // next word slot
    logic              merge_here;
    logic [WORD_W-1:0] beat_word;

    // a pending store lands on its own word as that beat arrives
    assign merge_here = (req.op == op_write)
                        && (beat_q == req.addr[OFFSET_W-1 -: WSEL_W]);
    assign beat_word  = merge_here ? merge_bytes(r_data, req.wdata, req.wstrb)
                                   : r_data;
    assign fill_done  = ret_valid && ret_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= '0;
        end else if (ret_valid) begin
            beat_q <= ret_last ? '0 : beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            fill_line[beat_q*WORD_W +: WORD_W] <= beat_word;
        end
    end

endmodule

// File: hdl/tag_store.sv
module tag_store
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] rd_index,
    input  logic [INDEX_W-1:0] wr_index,
    input  logic [TAG_W-1:0]   wr_tag,
    input  logic               wr_way,
    input  logic               tag_we,
    input  logic               dirty_set,
    input  logic               lru_touch,
    input  logic               touch_way,
    input  logic [TAG_W-1:0]   cmp_tag,
    output lookup_t            lookup
);
    logic [TAG_W-1:0] tag_mem [WAYS][SETS];
    logic [WAYS-1:0]  valid_q [SETS];
    logic [WAYS-1:0]  dirty_q [SETS];
    logic [SETS-1:0]  lru_q;              // holds the way to evict next

    logic [TAG_W-1:0] rd_tag [WAYS];
    logic [WAYS-1:0]  rd_valid;
    logic [WAYS-1:0]  rd_dirty;
    logic             rd_lru;
    logic [WAYS-1:0]  hit_vec;
    logic             vway;

    // tag array, no reset
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[wr_way][wr_index] <= wr_tag;
        end
        for (int w = 0; w < WAYS; w++) begin
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q    <= '0;                 // every set points at way 0
            rd_valid <= '0;
            rd_dirty <= '0;
            rd_lru   <= 1'b0;
        end else begin
            if (tag_we) begin
                valid_q[wr_index][wr_way] <= 1'b1;
                dirty_q[wr_index][wr_way] <= dirty_set;
            end
            if (lru_touch) begin
                lru_q[wr_index] <= ~touch_way;  // other way becomes victim
            end
            rd_valid <= valid_q[rd_index];
            rd_dirty <= dirty_q[rd_index];
            rd_lru   <= lru_q[rd_index];
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
        if (!rd_valid[0]) begin             // empty way first, way 0 preferred
            vway = 1'b0;
        end else if (!rd_valid[1]) begin
            vway = 1'b1;
        end else begin
            vway = rd_lru;
        end
        lookup.hit          = |hit_vec;
        lookup.hit_way      = hit_vec[1];
        lookup.victim_way   = vway;
        lookup.victim_valid = rd_valid[vway];
        lookup.victim_dirty = rd_dirty[vway];
        lookup.victim_tag   = rd_tag[vway];
    end

endmodule

// File: hdl/writeback_buf.sv
module writeback_buf
    import cache_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  logic [LINE_W-1:0] victim_line,
    input  logic [ADDR_W-1:0] victim_addr,
    input  logic              w_rdy,
    input  logic              w_data_ready,
    input  logic              b_valid,
    output logic              w_req,
    output logic [ADDR_W-1:0] w_addr,
    output logic [WORD_W-1:0] w_data,
    output logic              w_valid,
    output logic              w_last,
    output logic              b_ready,
    output logic              wb_done
);
    typedef enum logic [1:0] {wbs_idle, wbs_addr, wbs_data, wbs_resp} wb_state_e;

    wb_state_e         state_q;
    logic [LINE_W-1:0] line_q;
    logic [WSEL_W-1:0] beat_q;

    always_ff @(posedge clk) begin
        if (load) begin
            line_q <= victim_line;
            w_addr <= victim_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= wbs_idle;
            beat_q  <= '0;
        end else begin
            case (state_q)
                wbs_idle: if (load) state_q <= wbs_addr;
                wbs_addr: if (w_rdy) state_q <= wbs_data;  // address accepted
                wbs_data: if (w_data_ready) begin
                    beat_q <= beat_q + 1'b1;
                    if (w_last) state_q <= wbs_resp;
                end
                wbs_resp: if (b_valid) state_q <= wbs_idle;
                default:  state_q <= wbs_idle;
            endcase
        end
    end

    assign w_req   = (state_q == wbs_addr);
    assign w_valid = (state_q == wbs_data);
    assign w_last  = w_valid && (beat_q == WSEL_W'(WORDS - 1));
    assign w_data  = line_q[beat_q*WORD_W +: WORD_W];
    assign b_ready = (state_q == wbs_resp);
    assign wb_done = b_ready && b_valid;

endmodule

// File: tests/dcache_tb.sv
module dcache_tb
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;
();
    localparam int N_REQ    = 320;              // 11 directed, 300 random, spare
    localparam int MISS_CYC = 80;               // write-back plus fill under stalls
    localparam int LIMIT    = N_REQ * MISS_CYC + 200;

    logic              clk = 1'b0;
    logic              rst, valid, op;
    logic [ADDR_W-1:0] addr, r_addr, w_addr;
    logic [STRB_W-1:0] wstrb;
    logic [WORD_W-1:0] wdata, rdata, r_data, w_data;
    logic              data_valid, r_req, r_data_ready, r_rdy, ret_valid, ret_last;
    logic              w_req, w_valid, w_last, b_ready, w_rdy, w_data_ready, b_valid;

    // reference model state
    logic [WORD_W-1:0]         shadow [1024];
    logic [1:0][SETS-1:0][3:0] st = '0;       // tags as addr[11:8]
    logic [1:0][SETS-1:0]      sv = '0;
    logic [1:0][SETS-1:0]      sd = '0;
    logic [SETS-1:0]           slru = '0;
    logic [WORD_W-1:0]         exp_word;
    logic [ADDR_W-1:0]         exp_wb_addr;
    logic                      exp_hit, exp_wb, saw_rreq, saw_wreq;
    logic [1:0]                wb_beat;
    logic [31:0]               rng;
    int                        cycles = 0;
    int                        start_cyc, n_checks = 0, n_errors = 0;

    dcache i_dut (.*);
    mem_model i_mem (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, act, exp);
        end
    endtask

    // expected word and hit/write-back prediction, updates the shadow state
    function automatic logic [WORD_W-1:0] ref_access(input cpu_req_t req);
        logic [3:0]        idx;
        logic              way;
        logic [WORD_W-1:0] word;
        idx     = req.addr[7:4];
        way     = 1'b0;
        exp_hit = 1'b0;
        exp_wb  = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (sv[w][idx] && st[w][idx] == req.addr[11:8]) begin
                exp_hit = 1'b1;
                way     = w[0];
            end
        end
        if (!exp_hit) begin
            way          = !sv[0][idx] ? 1'b0 : (!sv[1][idx] ? 1'b1 : slru[idx]);
            exp_wb       = sv[way][idx] && sd[way][idx];
            exp_wb_addr  = {20'h0, st[way][idx], idx, 4'h0};
            st[way][idx] = req.addr[11:8];
            sv[way][idx] = 1'b1;
            sd[way][idx] = 1'b0;
        end
        slru[idx] = ~way;                       // other way goes next
        word = shadow[req.addr[11:2]];
        for (int b = 0; b < STRB_W; b++) begin
            if (req.op == op_write && req.wstrb[b]) begin
                word[8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
        shadow[req.addr[11:2]] = word;
        sd[way][idx] = sd[way][idx] | (req.op == op_write);
        return word;
    endfunction

    // one CPU request, held until data_valid
    task automatic access(input cpu_op_e o, input logic [11:0] a,
                          input logic [WORD_W-1:0] d, input logic [STRB_W-1:0] s);
        cpu_req_t req;
        req.addr  = {20'h0, a};
        req.wdata = d;
        req.op    = o;
        req.wstrb = s;
        exp_word  = ref_access(req);
        saw_rreq  = 1'b0;
        saw_wreq  = 1'b0;
        start_cyc = cycles;
        valid = 1'b1;
        op    = req.op;
        addr  = req.addr;
        wdata = req.wdata;
        wstrb = req.wstrb;
        @(negedge clk);
        while (!data_valid) @(negedge clk);
        @(posedge clk);
        #1 valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (r_req) begin
            saw_rreq = 1'b1;
            check("r_addr", r_addr, {addr[ADDR_W-1:OFFSET_W], 4'h0});
        end
        if (ret_valid) begin
            check("r_data_ready", r_data_ready, 1'b1);
        end
        if (w_req) begin
            saw_wreq = 1'b1;
            wb_beat  = '0;
            check("w_addr", w_addr, exp_wb_addr);
        end
        if (w_valid && w_data_ready) begin
            check("w_data", w_data, shadow[{exp_wb_addr[11:4], wb_beat}]);
            check("w_last", w_last, wb_beat == 2'd3);
            wb_beat = wb_beat + 1'b1;
        end
        if (b_valid) begin
            check("b_ready", b_ready, 1'b1);
        end
        if (data_valid) begin
            if (op == op_read) check("rdata", rdata, exp_word);
            check("r_req_seen", saw_rreq, !exp_hit);
            check("w_req_seen", saw_wreq, exp_wb);
            if (exp_hit) check("hit_latency", cycles - start_cyc, 1);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: request still open after %0d cycles", cycles);
            $display("checks %0d, errors %0d", n_checks, n_errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        rng = 32'd31;                           // same sequence as the memory preload
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = lcg_next();
        end
        rst   = 1'b1;
        valid = 1'b0;
        op    = 1'b0;
        addr  = '0;
        wstrb = '0;
        wdata = '0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        check("ctrl_out", {data_valid, r_req, w_req, w_valid, w_last, b_ready, r_data_ready}, 0);
        access(op_read, 12'h040, '0, '0);       // cold miss
        access(op_read, 12'h044, '0, '0);
        access(op_read, 12'h04c, '0, '0);
        access(op_write, 12'h044, lcg_next(), 4'(lcg_next() >> 28));
        access(op_read, 12'h044, '0, '0);
        access(op_write, 12'h358, lcg_next(), 4'b0110);    // store miss
        access(op_read, 12'h358, '0, '0);
        access(op_read, 12'h354, '0, '0);
        access(op_read, 12'h140, '0, '0);
        access(op_read, 12'h240, '0, '0);       // third tag in set 4 evicts dirty line
        access(op_read, 12'h044, '0, '0);
        repeat (300) begin
            r = lcg_next();
            access(cpu_op_e'(r[22]), {2'b00, r[17:16], 2'b00, r[19:18], r[21:20], 2'b00},
                   lcg_next(), r[26:23]);
        end
        @(posedge clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tests/mem_model.sv
module mem_model
    import cache_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              r_req,
    input  logic [ADDR_W-1:0] r_addr,
    output logic              r_rdy,
    output logic              ret_valid,
    output logic              ret_last,
    output logic [WORD_W-1:0] r_data,
    input  logic [ADDR_W-1:0] w_addr,
    input  logic [WORD_W-1:0] w_data,
    input  logic              w_valid,
    input  logic              w_last,
    output logic              w_rdy,
    output logic              w_data_ready,
    output logic              b_valid
);
    logic [WORD_W-1:0] mem [1024];          // 4 KiB, word addressed
    logic [31:0]       rng;
    logic [31:0]       rnd;
    logic [2:0]        go;                  // ready strobes, redrawn every cycle
    logic [7:0]        rd_line;
    logic [1:0]        rd_beat, wr_beat;
    logic              rd_busy, b_pend;

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    initial begin
        rng = 32'd31;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = lcg_next();
        end
        go        = '0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        r_data    = '0;
        b_valid   = 1'b0;
    end

    assign r_rdy        = go[0];
    assign w_rdy        = go[1];
    assign w_data_ready = go[2];

    always @(posedge clk) begin
        rnd = lcg_next();
        go        <= {|rnd[31:30], |rnd[29:28], |rnd[27:26]};  // ready 3 cycles in 4
        ret_valid <= 1'b0;
        ret_last  <= 1'b0;
        b_valid   <= 1'b0;
        if (rst) begin
            rd_busy <= 1'b0;
            rd_beat <= '0;
            wr_beat <= '0;
            b_pend  <= 1'b0;
        end else begin
            if (r_req && r_rdy) begin       // read address accepted
                rd_busy <= 1'b1;
                rd_line <= r_addr[11:4];
            end
            if (rd_busy && |rnd[25:24]) begin
                ret_valid <= 1'b1;
                ret_last  <= (rd_beat == 2'd3);
                r_data    <= mem[{rd_line, rd_beat}];
                rd_beat   <= rd_beat + 1'b1;
                rd_busy   <= (rd_beat != 2'd3);
            end
            if (w_valid && w_data_ready) begin
                mem[{w_addr[11:4], wr_beat}] <= w_data;
                wr_beat <= wr_beat + 1'b1;
                b_pend  <= w_last;
            end
            if (b_pend && |rnd[23:22]) begin    // write response, one cycle
                b_valid <= 1'b1;
                b_pend  <= 1'b0;
            end
        end
    end

endmodule
